/* hdl/tsc_alu.sv */
module tsc_alu (
    input  logic [tsc_isa_pkg::word_size-1:0] a,
    input  logic [tsc_isa_pkg::word_size-1:0] b,
    input  tsc_pipe_pkg::alu_op_t             op,
    output logic [tsc_isa_pkg::word_size-1:0] result
);

    always_comb begin
        case (op)
            tsc_pipe_pkg::alu_add: result = a + b;
            tsc_pipe_pkg::alu_sub: result = a - b;
            tsc_pipe_pkg::alu_and: result = a & b;
            tsc_pipe_pkg::alu_or:  result = a | b;
            tsc_pipe_pkg::alu_not: result = ~a;
            tsc_pipe_pkg::alu_shl: result = {a[tsc_isa_pkg::word_size-2:0], 1'b0};
            // arithmetic, sign bit kept
            tsc_pipe_pkg::alu_shr: begin
                result = {a[tsc_isa_pkg::word_size-1], a[tsc_isa_pkg::word_size-1:1]};
            end
            tsc_pipe_pkg::alu_lhi: result = b << (tsc_isa_pkg::word_size / 2);
            tsc_pipe_pkg::alu_pass_a: result = a; // wwd
            default: result = a;
        endcase
    end

endmodule

/* hdl/tsc_branch_unit.sv */
module tsc_branch_unit (
    input  logic [tsc_isa_pkg::word_size-1:0] instr,
    input  logic [tsc_isa_pkg::word_size-1:0] pc_plus1,
    input  logic [tsc_isa_pkg::word_size-1:0] rs_data,
    input  logic [tsc_isa_pkg::word_size-1:0] rt_data,
    output logic [tsc_isa_pkg::word_size-1:0] imm,
    output logic [tsc_isa_pkg::word_size-1:0] branch_target,
    output logic [tsc_isa_pkg::word_size-1:0] jump_target,
    output logic                              eq_flag
);
    tsc_isa_pkg::opcode_t opcode;
    logic [7:0] imm8;
    logic       zero_ext;

    assign opcode = tsc_isa_pkg::opcode_t'(
        instr[tsc_isa_pkg::opcode_msb:tsc_isa_pkg::opcode_lsb]);
    assign imm8 = instr[tsc_isa_pkg::imm8_msb:tsc_isa_pkg::imm8_lsb];

    // logical immediates are unsigned
    assign zero_ext = opcode == tsc_isa_pkg::op_ori || opcode == tsc_isa_pkg::op_lhi;
    assign imm = zero_ext ? {{(tsc_isa_pkg::word_size-8){1'b0}}, imm8}
                          : {{(tsc_isa_pkg::word_size-8){imm8[7]}}, imm8};

    assign branch_target = pc_plus1 + imm;
    assign jump_target = {pc_plus1[tsc_isa_pkg::word_size-1:tsc_isa_pkg::target_msb+1],
                          instr[tsc_isa_pkg::target_msb:tsc_isa_pkg::target_lsb]};

    assign eq_flag = rs_data == rt_data;

endmodule

/* hdl/tsc_control.sv */
module tsc_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [15:0]            id_instr,
    input  logic                   id_valid,
    input  logic                   eq_flag,
    input  logic [1:0]             ex_rd,
    input  logic                   ex_reg_write,
    input  logic                   ex_mem_read,
    input  logic [1:0]             mem_rd,
    input  logic                   mem_reg_write,
    input  logic [1:0]             wb_rd,
    input  logic                   wb_reg_write,
    input  logic [1:0]             ex_rs,
    input  logic [1:0]             ex_rt,
    input  logic                   halted,
    output tsc_pipe_pkg::pc_src_t  pc_src,
    output logic                   pc_write,
    output logic                   ifid_write,
    output logic                   ifid_flush,
    output logic                   idex_bubble,
    output logic                   id_reg_write,
    output logic                   id_mem_read,
    output logic                   id_mem_write,
    output logic                   id_mem_to_reg,
    output logic                   id_alu_src_imm,
    output tsc_pipe_pkg::alu_op_t  id_alu_op,
    output logic [1:0]             id_dest,
    output logic                   id_is_wwd,
    output logic                   id_is_hlt,
    output tsc_pipe_pkg::fwd_sel_t fwd_a,
    output tsc_pipe_pkg::fwd_sel_t fwd_b
);
    tsc_isa_pkg::opcode_t opcode;
    tsc_isa_pkg::func_t   func;
    logic [1:0] rs, rt, rd;
    logic uses_rs, uses_rt, is_branch, is_jump;
    logic load_use, branch_hazard, stall, hlt_stop, halt_pend;

    function automatic tsc_pipe_pkg::fwd_sel_t pick_fwd(
        input logic [1:0] src,
        input logic       m_we,
        input logic [1:0] m_rd,
        input logic       w_we,
        input logic [1:0] w_rd
    );
        if (m_we && m_rd == src)
            return tsc_pipe_pkg::fwd_mem; // youngest result wins
        if (w_we && w_rd == src)
            return tsc_pipe_pkg::fwd_wb;
        return tsc_pipe_pkg::fwd_none;
    endfunction

    assign opcode = tsc_isa_pkg::opcode_t'(
        id_instr[tsc_isa_pkg::opcode_msb:tsc_isa_pkg::opcode_lsb]);
    assign func = tsc_isa_pkg::func_t'(id_instr[tsc_isa_pkg::func_msb:tsc_isa_pkg::func_lsb]);
    assign rs = id_instr[tsc_isa_pkg::rs_msb:tsc_isa_pkg::rs_lsb];
    assign rt = id_instr[tsc_isa_pkg::rt_msb:tsc_isa_pkg::rt_lsb];
    assign rd = id_instr[tsc_isa_pkg::rd_msb:tsc_isa_pkg::rd_lsb];

    always_comb begin
        id_reg_write   = 1'b0;
        id_mem_read    = 1'b0;
        id_mem_write   = 1'b0;
        id_mem_to_reg  = 1'b0;
        id_alu_src_imm = 1'b1;
        id_alu_op      = tsc_pipe_pkg::alu_add;
        id_dest        = rt;
        id_is_wwd      = 1'b0;
        id_is_hlt      = 1'b0;
        uses_rs        = 1'b0;
        uses_rt        = 1'b0;
        is_branch      = 1'b0;
        is_jump        = 1'b0;
        if (id_valid) begin
            uses_rs = 1'b1;
            case (opcode)
                tsc_isa_pkg::op_rtype: begin
                    id_alu_src_imm = 1'b0;
                    id_dest        = rd;
                    id_reg_write   = 1'b1;
                    uses_rt        = 1'b1; // conservative for unary ops
                    case (func)
                        tsc_isa_pkg::fn_add: id_alu_op = tsc_pipe_pkg::alu_add;
                        tsc_isa_pkg::fn_sub: id_alu_op = tsc_pipe_pkg::alu_sub;
                        tsc_isa_pkg::fn_and: id_alu_op = tsc_pipe_pkg::alu_and;
                        tsc_isa_pkg::fn_orr: id_alu_op = tsc_pipe_pkg::alu_or;
                        tsc_isa_pkg::fn_not: id_alu_op = tsc_pipe_pkg::alu_not;
                        tsc_isa_pkg::fn_shl: id_alu_op = tsc_pipe_pkg::alu_shl;
                        tsc_isa_pkg::fn_shr: id_alu_op = tsc_pipe_pkg::alu_shr;
                        tsc_isa_pkg::fn_wwd: begin
                            id_alu_op    = tsc_pipe_pkg::alu_pass_a;
                            id_reg_write = 1'b0;
                            id_is_wwd    = 1'b1;
                        end
                        tsc_isa_pkg::fn_hlt: begin
                            // no operands, so hlt never stalls
                            id_reg_write = 1'b0;
                            id_is_hlt    = 1'b1;
                            uses_rs      = 1'b0;
                            uses_rt      = 1'b0;
                        end
                        default: id_reg_write = 1'b0;
                    endcase
                end
                tsc_isa_pkg::op_adi: id_reg_write = 1'b1;
                tsc_isa_pkg::op_ori: begin
                    id_reg_write = 1'b1;
                    id_alu_op    = tsc_pipe_pkg::alu_or;
                end
                tsc_isa_pkg::op_lhi: begin
                    id_reg_write = 1'b1;
                    id_alu_op    = tsc_pipe_pkg::alu_lhi;
                    uses_rs      = 1'b0;
                end
                tsc_isa_pkg::op_lwd: begin
                    id_reg_write  = 1'b1;
                    id_mem_read   = 1'b1;
                    id_mem_to_reg = 1'b1;
                end
                tsc_isa_pkg::op_swd: begin
                    id_mem_write = 1'b1;
                    uses_rt      = 1'b1; // store data
                end
                tsc_isa_pkg::op_bne, tsc_isa_pkg::op_beq: begin
                    is_branch = 1'b1;
                    uses_rt   = 1'b1;
                end
                tsc_isa_pkg::op_jmp: begin
                    is_jump = 1'b1;
                    uses_rs = 1'b0;
                end
                default: uses_rs = 1'b0;
            endcase
        end
    end

    assign load_use = ex_mem_read && ((uses_rs && ex_rd == rs) || (uses_rt && ex_rd == rt));
    // branch compares in decode, so producers still in ex or mem must drain first
    assign branch_hazard = is_branch &&
        ((ex_reg_write && (ex_rd == rs || ex_rd == rt)) ||
         (mem_reg_write && (mem_rd == rs || mem_rd == rt)));
    assign stall    = load_use || branch_hazard;
    assign hlt_stop = id_is_hlt || halt_pend || halted;

    always_comb begin
        pc_src = tsc_pipe_pkg::pc_seq;
        if (is_jump)
            pc_src = tsc_pipe_pkg::pc_jump;
        else if (is_branch && !stall && eq_flag == (opcode == tsc_isa_pkg::op_beq))
            pc_src = tsc_pipe_pkg::pc_branch;
    end

    assign pc_write    = !stall && !hlt_stop;
    assign ifid_write  = !stall;
    assign ifid_flush  = pc_src != tsc_pipe_pkg::pc_seq || (hlt_stop && !stall);
    assign idex_bubble = stall;

    assign fwd_a = pick_fwd(ex_rs, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
    assign fwd_b = pick_fwd(ex_rt, mem_reg_write, mem_rd, wb_reg_write, wb_rd);

    // sticky once hlt passes decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            halt_pend <= 1'b0;
        else if (id_is_hlt)
            halt_pend <= 1'b1;
    end

endmodule

/* hdl/tsc_cpu.sv */
module tsc_cpu (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic                              i_read,
    output logic [tsc_isa_pkg::word_size-1:0] i_addr,
    input  logic [tsc_isa_pkg::word_size-1:0] i_data,
    output logic                              d_read,
    output logic                              d_write,
    output logic [tsc_isa_pkg::word_size-1:0] d_addr,
    output logic [tsc_isa_pkg::word_size-1:0] d_wdata,
    input  logic [tsc_isa_pkg::word_size-1:0] d_rdata,
    output logic [tsc_isa_pkg::word_size-1:0] num_inst,
    output logic [tsc_isa_pkg::word_size-1:0] output_port,
    output logic                              output_valid,
    output logic                              is_halted
);
    logic [tsc_isa_pkg::word_size-1:0] pc, pc_next;
    tsc_pipe_pkg::pc_src_t pc_src;
    logic pc_write, ifid_write, ifid_flush, idex_bubble;

    logic                              ifid_valid;
    logic [tsc_isa_pkg::word_size-1:0] ifid_instr, ifid_pc1;

    // decode stage
    logic [tsc_isa_pkg::word_size-1:0] rs_data, rt_data, imm, branch_target, jump_target;
    logic eq_flag, id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg;
    logic id_alu_src_imm, id_is_wwd, id_is_hlt;
    logic [1:0] id_dest;
    tsc_pipe_pkg::alu_op_t id_alu_op;

    logic idex_valid, idex_reg_write, idex_mem_read, idex_mem_write, idex_is_wwd, idex_is_hlt;
    logic idex_mem_to_reg, idex_alu_src_imm;
    logic [1:0] idex_dest, idex_rs, idex_rt;
    tsc_pipe_pkg::alu_op_t idex_alu_op;
    logic [tsc_isa_pkg::word_size-1:0] idex_a, idex_b, idex_imm;

    // execute stage
    tsc_pipe_pkg::fwd_sel_t fwd_a, fwd_b;
    logic [tsc_isa_pkg::word_size-1:0] op_a, op_b, alu_b, alu_result;

    logic exmem_valid, exmem_reg_write, exmem_mem_read, exmem_mem_write;
    logic exmem_is_wwd, exmem_is_hlt, exmem_mem_to_reg;
    logic [1:0] exmem_dest;
    logic [tsc_isa_pkg::word_size-1:0] exmem_alu, exmem_store;

    logic memwb_valid, memwb_reg_write, memwb_is_wwd, memwb_is_hlt, memwb_mem_to_reg;
    logic [1:0] memwb_dest;
    logic [tsc_isa_pkg::word_size-1:0] memwb_alu, memwb_mem_data, wb_data;

    function automatic logic [tsc_isa_pkg::word_size-1:0] fwd_mux(
        input tsc_pipe_pkg::fwd_sel_t            sel,
        input logic [tsc_isa_pkg::word_size-1:0] reg_val,
        input logic [tsc_isa_pkg::word_size-1:0] mem_val,
        input logic [tsc_isa_pkg::word_size-1:0] wb_val
    );
        case (sel)
            tsc_pipe_pkg::fwd_mem: return mem_val;
            tsc_pipe_pkg::fwd_wb:  return wb_val;
            default:               return reg_val;
        endcase
    endfunction

    always_comb begin
        case (pc_src)
            tsc_pipe_pkg::pc_branch: pc_next = branch_target;
            tsc_pipe_pkg::pc_jump:   pc_next = jump_target;
            default:                 pc_next = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= '0;
        else if (pc_write)
            pc <= pc_next;
    end

    assign i_read = pc_write; // low on stall and after hlt
    assign i_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ifid_valid <= 1'b0;
        else if (ifid_flush)
            ifid_valid <= 1'b0;
        else if (ifid_write)
            ifid_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (ifid_write) begin
            ifid_instr <= i_data;
            ifid_pc1   <= pc + 1'b1;
        end
    end

    tsc_control control_inst (
        .clk(clk), .rst_n(rst_n), .id_instr(ifid_instr), .id_valid(ifid_valid),
        .eq_flag(eq_flag), .ex_rd(idex_dest), .ex_reg_write(idex_reg_write),
        .ex_mem_read(idex_mem_read), .mem_rd(exmem_dest), .mem_reg_write(exmem_reg_write),
        .wb_rd(memwb_dest), .wb_reg_write(memwb_reg_write), .ex_rs(idex_rs),
        .ex_rt(idex_rt), .halted(is_halted), .pc_src(pc_src), .pc_write(pc_write),
        .ifid_write(ifid_write), .ifid_flush(ifid_flush), .idex_bubble(idex_bubble),
        .id_reg_write(id_reg_write), .id_mem_read(id_mem_read),
        .id_mem_write(id_mem_write), .id_mem_to_reg(id_mem_to_reg),
        .id_alu_src_imm(id_alu_src_imm), .id_alu_op(id_alu_op), .id_dest(id_dest),
        .id_is_wwd(id_is_wwd), .id_is_hlt(id_is_hlt), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    tsc_regfile regfile_inst (
        .clk(clk), .rst_n(rst_n),
        .rs(ifid_instr[tsc_isa_pkg::rs_msb:tsc_isa_pkg::rs_lsb]),
        .rt(ifid_instr[tsc_isa_pkg::rt_msb:tsc_isa_pkg::rt_lsb]),
        .wr_addr(memwb_dest), .wr_data(wb_data), .wr_en(memwb_reg_write),
        .rs_data(rs_data), .rt_data(rt_data)
    );

    tsc_branch_unit branch_unit_inst (
        .instr(ifid_instr), .pc_plus1(ifid_pc1), .rs_data(rs_data), .rt_data(rt_data),
        .imm(imm), .branch_target(branch_target), .jump_target(jump_target),
        .eq_flag(eq_flag)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid     <= 1'b0;
            idex_reg_write <= 1'b0;
            idex_mem_read  <= 1'b0;
            idex_mem_write <= 1'b0;
            idex_is_wwd    <= 1'b0;
            idex_is_hlt    <= 1'b0;
        end else begin
            // stall turns the decode slot into a bubble
            idex_valid     <= ifid_valid && !idex_bubble;
            idex_reg_write <= id_reg_write && !idex_bubble;
            idex_mem_read  <= id_mem_read && !idex_bubble;
            idex_mem_write <= id_mem_write && !idex_bubble;
            idex_is_wwd    <= id_is_wwd && !idex_bubble;
            idex_is_hlt    <= id_is_hlt && !idex_bubble;
        end
    end

    always_ff @(posedge clk) begin
        idex_mem_to_reg  <= id_mem_to_reg;
        idex_alu_src_imm <= id_alu_src_imm;
        idex_alu_op      <= id_alu_op;
        idex_dest        <= id_dest;
        idex_rs          <= ifid_instr[tsc_isa_pkg::rs_msb:tsc_isa_pkg::rs_lsb];
        idex_rt          <= ifid_instr[tsc_isa_pkg::rt_msb:tsc_isa_pkg::rt_lsb];
        idex_a           <= rs_data;
        idex_b           <= rt_data;
        idex_imm         <= imm;
    end

    assign op_a  = fwd_mux(fwd_a, idex_a, exmem_alu, wb_data);
    assign op_b  = fwd_mux(fwd_b, idex_b, exmem_alu, wb_data);
    assign alu_b = idex_alu_src_imm ? idex_imm : op_b;

    tsc_alu alu_inst (
        .a(op_a), .b(alu_b), .op(idex_alu_op), .result(alu_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_valid     <= 1'b0;
            exmem_reg_write <= 1'b0;
            exmem_mem_read  <= 1'b0;
            exmem_mem_write <= 1'b0;
            exmem_is_wwd    <= 1'b0;
            exmem_is_hlt    <= 1'b0;
        end else begin
            exmem_valid     <= idex_valid;
            exmem_reg_write <= idex_reg_write;
            exmem_mem_read  <= idex_mem_read;
            exmem_mem_write <= idex_mem_write;
            exmem_is_wwd    <= idex_is_wwd;
            exmem_is_hlt    <= idex_is_hlt;
        end
    end

    always_ff @(posedge clk) begin
        exmem_mem_to_reg <= idex_mem_to_reg;
        exmem_dest       <= idex_dest;
        exmem_alu        <= alu_result;
        exmem_store      <= op_b; // forwarded rt for swd
    end

    assign d_read  = exmem_mem_read;
    assign d_write = exmem_mem_write;
    assign d_addr  = exmem_alu;
    assign d_wdata = exmem_store;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memwb_valid     <= 1'b0;
            memwb_reg_write <= 1'b0;
            memwb_is_wwd    <= 1'b0;
            memwb_is_hlt    <= 1'b0;
        end else begin
            memwb_valid     <= exmem_valid;
            memwb_reg_write <= exmem_reg_write;
            memwb_is_wwd    <= exmem_is_wwd;
            memwb_is_hlt    <= exmem_is_hlt;
        end
    end

    always_ff @(posedge clk) begin
        memwb_mem_to_reg <= exmem_mem_to_reg;
        memwb_dest       <= exmem_dest;
        memwb_alu        <= exmem_alu;
        memwb_mem_data   <= d_rdata;
    end

    assign wb_data      = memwb_mem_to_reg ? memwb_mem_data : memwb_alu;
    assign output_port  = memwb_alu; // wwd passes rs through the alu
    assign output_valid = memwb_valid && memwb_is_wwd;

    // retire count and halt flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_inst  <= '0;
            is_halted <= 1'b0;
        end else begin
            if (memwb_valid)
                num_inst <= num_inst + 1'b1;
            if (memwb_valid && memwb_is_hlt)
                is_halted <= 1'b1;
        end
    end

endmodule

/* hdl/tsc_isa_pkg.sv */
package tsc_isa_pkg;

    localparam int word_size = 16;
    localparam int reg_count = 4;

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_rtype = 4'd15
    } opcode_t;

    // function field, only meaningful with op_rtype
    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_shl = 6'd6,
        fn_shr = 6'd7,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_t;

    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;
    localparam int rs_msb     = 11;
    localparam int rs_lsb     = 10;
    localparam int rt_msb     = 9;
    localparam int rt_lsb     = 8;
    localparam int rd_msb     = 7;
    localparam int rd_lsb     = 6;
    localparam int func_msb   = 5;
    localparam int func_lsb   = 0;
    localparam int imm8_msb   = 7;
    localparam int imm8_lsb   = 0;
    localparam int target_msb = 11; // jmp target12
    localparam int target_lsb = 0;

endpackage

/* hdl/tsc_pipe_pkg.sv */
package tsc_pipe_pkg;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef enum logic [1:0] {
        pc_seq,
        pc_branch,
        pc_jump
    } pc_src_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_shl,
        alu_shr,
        alu_lhi,
        alu_pass_a
    } alu_op_t;

endpackage

/* hdl/tsc_regfile.sv */
module tsc_regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [1:0]                        rs,
    input  logic [1:0]                        rt,
    input  logic [1:0]                        wr_addr,
    input  logic [tsc_isa_pkg::word_size-1:0] wr_data,
    input  logic                              wr_en,
    output logic [tsc_isa_pkg::word_size-1:0] rs_data,
    output logic [tsc_isa_pkg::word_size-1:0] rt_data
);
    logic [tsc_isa_pkg::word_size-1:0] regs [tsc_isa_pkg::reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < tsc_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-first bypass so decode sees this cycle's writeback
    assign rs_data = (wr_en && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_data = (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, then judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tsc_cpu_tb -f tsc_pipe.f \
    && ./obj_dir/Vtsc_cpu_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -q "SIMULATION FAILED" sim.log 2>/dev/null && { echo "result: failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log 2>/dev/null || { echo "result: run did not complete"; exit 1; }
echo "result: passed"
exit 0

/* testbench/tsc_cpu_assert.sv */
module tsc_cpu_assert (
    input logic clk,
    input logic rst_n,
    input logic i_read,
    input logic d_read,
    input logic d_write,
    input logic output_valid,
    input logic is_halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // one data access per cycle
    no_read_write_overlap: assert property (
        @(posedge clk) disable iff (!rst_n) !(d_read && d_write)
    ) else $error("d_read and d_write are high in the same cycle");

    halt_is_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) $past(is_halted) |-> is_halted
    ) else $error("is_halted dropped after it was set");

    no_output_in_reset: assert property (
        @(posedge clk) !rst_n |-> !output_valid
    ) else $error("output_valid high while reset is asserted");

    fetch_stops_on_halt: assert property (
        @(posedge clk) disable iff (!rst_n) is_halted |-> !i_read
    ) else $error("i_read high while the cpu is halted");

endmodule

bind tsc_cpu tsc_cpu_assert tsc_cpu_assert_inst (
    .clk(clk), .rst_n(rst_n), .i_read(i_read), .d_read(d_read), .d_write(d_write),
    .output_valid(output_valid), .is_halted(is_halted)
);

/* testbench/tsc_cpu_tb.sv */
module tsc_cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int prog_len     = 60;
    localparam int halt_timeout = 2000;
    localparam logic [15:0] hlt_word = {tsc_isa_pkg::op_rtype, 6'd0, tsc_isa_pkg::fn_hlt};

    logic        clk, rst_n;
    logic        i_read, d_read, d_write, output_valid, is_halted;
    logic [15:0] i_addr, i_data, d_addr, d_wdata, d_rdata;
    logic [15:0] num_inst, output_port;

    logic [15:0] imem [128];
    logic [15:0] dmem [64];
    logic [15:0] m_regs [4]; // reference model state
    logic [15:0] m_mem [64];
    logic [15:0] exp_out [$];
    logic [15:0] exp_st_addr [$];
    logic [15:0] exp_st_data [$];
    logic [15:0] exp_ld_addr [$];
    int          exp_count, out_idx, st_idx, ld_idx, value_errors, other_errors;
    integer      seed;

    tsc_cpu tsc_cpu_inst (
        .clk(clk), .rst_n(rst_n), .i_read(i_read), .i_addr(i_addr), .i_data(i_data),
        .d_read(d_read), .d_write(d_write), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_rdata(d_rdata), .num_inst(num_inst), .output_port(output_port),
        .output_valid(output_valid), .is_halted(is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] fill_word(input int addr);
        logic [15:0] a;
        a = addr[15:0];
        return (a * 16'h9e37) ^ 16'h5a5a;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [5:0] pick_alu_fn();
        case (rand_below(7))
            0: return tsc_isa_pkg::fn_add;
            1: return tsc_isa_pkg::fn_sub;
            2: return tsc_isa_pkg::fn_and;
            3: return tsc_isa_pkg::fn_orr;
            4: return tsc_isa_pkg::fn_not;
            5: return tsc_isa_pkg::fn_shl;
            default: return tsc_isa_pkg::fn_shr;
        endcase
    endfunction

    // same-cycle memories, writes land on the clock edge
    assign i_data  = imem[i_addr[6:0]];
    assign d_rdata = dmem[d_addr[5:0]];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 64; k++)
                dmem[k] <= fill_word(k);
        end else if (d_write) begin
            dmem[d_addr[5:0]] <= d_wdata;
        end
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
        end
    endtask

    task automatic build_program();
        logic [1:0] rs, rt, rd;
        logic [7:0] imm;
        int kind, room, off;
        for (int k = 0; k < 128; k++)
            imem[k] = hlt_word;
        for (int i = 0; i < prog_len; i++) begin
            rs   = 2'(rand_below(4));
            rt   = 2'(rand_below(4));
            rd   = 2'(rand_below(4));
            imm  = 8'(rand_below(256));
            room = prog_len - 1 - i; // forward slots left before the final hlt
            kind = rand_below(19);
            if (kind >= 16 && room < 1)
                kind = 14;
            if (kind < 6)
                imem[i] = {tsc_isa_pkg::op_rtype, rs, rt, rd, pick_alu_fn()};
            else if (kind < 8)
                imem[i] = {tsc_isa_pkg::op_adi, rs, rt, imm};
            else if (kind == 8)
                imem[i] = {tsc_isa_pkg::op_ori, rs, rt, imm};
            else if (kind == 9)
                imem[i] = {tsc_isa_pkg::op_lhi, rs, rt, imm};
            else if (kind < 12)
                imem[i] = {tsc_isa_pkg::op_lwd, rs, rt, imm};
            else if (kind < 14)
                imem[i] = {tsc_isa_pkg::op_swd, rs, rt, imm};
            else if (kind < 16)
                imem[i] = {tsc_isa_pkg::op_rtype, rs, rt, rd, tsc_isa_pkg::fn_wwd};
            else begin
                off = 1 + rand_below(room < 4 ? room : 4);
                if (rand_below(2) == 0)
                    rt = rs; // equal operands, so beq takes and bne falls through
                if (kind == 16)
                    imem[i] = {tsc_isa_pkg::op_beq, rs, rt, 8'(off)};
                else if (kind == 17)
                    imem[i] = {tsc_isa_pkg::op_bne, rs, rt, 8'(off)};
                else
                    imem[i] = {tsc_isa_pkg::op_jmp, 12'(i + 1 + off)};
            end
        end
        imem[prog_len] = hlt_word;
    endtask

    // sequential isa model, one instruction per step
    task automatic run_model();
        logic [15:0] ins, a, b, simm, addr;
        logic [1:0] rs, rt, rd;
        int pc, steps;
        bit done;
        for (int r = 0; r < 4; r++)
            m_regs[r] = '0;
        for (int k = 0; k < 64; k++)
            m_mem[k] = fill_word(k);
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 500) begin
            ins  = imem[pc[6:0]];
            rs   = ins[11:10];
            rt   = ins[9:8];
            rd   = ins[7:6];
            a    = m_regs[rs];
            b    = m_regs[rt];
            simm = {{8{ins[7]}}, ins[7:0]};
            addr = a + simm;
            steps++;
            pc++;
            case (ins[15:12])
                tsc_isa_pkg::op_rtype: begin
                    case (ins[5:0])
                        tsc_isa_pkg::fn_add: m_regs[rd] = a + b;
                        tsc_isa_pkg::fn_sub: m_regs[rd] = a - b;
                        tsc_isa_pkg::fn_and: m_regs[rd] = a & b;
                        tsc_isa_pkg::fn_orr: m_regs[rd] = a | b;
                        tsc_isa_pkg::fn_not: m_regs[rd] = ~a;
                        tsc_isa_pkg::fn_shl: m_regs[rd] = {a[14:0], 1'b0};
                        tsc_isa_pkg::fn_shr: m_regs[rd] = {a[15], a[15:1]};
                        tsc_isa_pkg::fn_wwd: exp_out.push_back(a);
                        tsc_isa_pkg::fn_hlt: done = 1'b1;
                        default: ;
                    endcase
                end
                tsc_isa_pkg::op_adi: m_regs[rt] = a + simm;
                tsc_isa_pkg::op_ori: m_regs[rt] = a | {8'h00, ins[7:0]};
                tsc_isa_pkg::op_lhi: m_regs[rt] = {ins[7:0], 8'h00};
                tsc_isa_pkg::op_lwd: begin
                    exp_ld_addr.push_back(addr);
                    m_regs[rt] = m_mem[addr[5:0]]; // 64-word data memory
                end
                tsc_isa_pkg::op_swd: begin
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    m_mem[addr[5:0]] = b;
                end
                tsc_isa_pkg::op_bne: if (a != b) pc = pc + int'($signed(simm));
                tsc_isa_pkg::op_beq: if (a == b) pc = pc + int'($signed(simm));
                tsc_isa_pkg::op_jmp: pc = int'(ins[11:0]);
                default: ;
            endcase
        end
        exp_count = steps;
    endtask

    task automatic observe_cycle(input bit after_halt);
        if (output_valid) begin
            if (after_halt || out_idx >= exp_out.size()) begin
                other_errors++;
                $display("output_valid pulsed at %0t with no WWD left to retire", $time);
            end else begin
                check_value("output_port", output_port, exp_out[out_idx]);
            end
            out_idx++;
        end
        if (d_write) begin
            if (after_halt || st_idx >= exp_st_addr.size()) begin
                other_errors++;
                $display("d_write seen at %0t with no store left to retire", $time);
            end else begin
                check_value("d_addr", d_addr, exp_st_addr[st_idx]);
                check_value("d_wdata", d_wdata, exp_st_data[st_idx]);
            end
            st_idx++;
        end
        if (d_read) begin
            if (after_halt || ld_idx >= exp_ld_addr.size()) begin
                other_errors++;
                $display("d_read seen at %0t with no load left to retire", $time);
            end else begin
                check_value("d_addr", d_addr, exp_ld_addr[ld_idx]);
            end
            ld_idx++;
        end
    endtask

    initial begin
        int cycles;
        seed         = 32'h2cfcf077;
        value_errors = 0;
        other_errors = 0;
        out_idx      = 0;
        st_idx       = 0;
        ld_idx       = 0;
        rst_n        = 1'b0;
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        check_value("i_addr", i_addr, 16'h0000);
        check_value("is_halted", 16'(is_halted), 16'h0000);
        check_value("i_read", 16'(i_read), 16'h0001);
        check_value("d_read", 16'(d_read), 16'h0000);
        check_value("d_write", 16'(d_write), 16'h0000);
        check_value("output_valid", 16'(output_valid), 16'h0000);
        cycles = 0;
        while (!is_halted && cycles < halt_timeout) begin
            @(negedge clk);
            observe_cycle(1'b0);
            cycles++;
        end
        if (!is_halted) begin
            other_errors++;
            $display("timeout: is_halted still low after %0d cycles", halt_timeout);
        end else begin
            check_value("num_inst", num_inst, 16'(exp_count));
            check_value("wwd_count", 16'(out_idx), 16'(exp_out.size()));
            check_value("store_count", 16'(st_idx), 16'(exp_st_addr.size()));
            check_value("load_count", 16'(ld_idx), 16'(exp_ld_addr.size()));
            for (int k = 0; k < 20; k++) begin
                @(negedge clk);
                observe_cycle(1'b1); // nothing may retire now
            end
        end
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tsc_pipe.f */
hdl/tsc_isa_pkg.sv
hdl/tsc_pipe_pkg.sv
hdl/tsc_alu.sv
hdl/tsc_regfile.sv
hdl/tsc_branch_unit.sv
hdl/tsc_control.sv
hdl/tsc_cpu.sv
testbench/tsc_cpu_assert.sv
testbench/tsc_cpu_tb.sv
